// File: board_filler.sv
`timescale 1ns/1ps
`default_nettype none

module board_filler import match_board_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  game_reset,
    output cell_write_t wr
);

    localparam grid_index_t GRID_LAST = grid_index_t'(GRID_SIZE - 1);

    logic [2:0]  lfsr;
    symbol_t     candidate;
    logic        accept;
    cell_addr_t  fill_addr;
    logic        wr_en;
    cell_addr_t  wr_addr;
    symbol_t     wr_value;

    //////////////////////////////
    // random source
    //////////////////////////////

    // 3-bit maximal lfsr cycling through 1..7
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= 3'd1;
        end else begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    // lfsr never hits 0, so shift down by one
    assign candidate = lfsr - 3'd1;
    // codes of 5 and up are dropped
    assign accept = game_reset && (candidate < symbol_t'(NUM_SYMBOLS));

    //////////////////////////////
    // fill walk
    //////////////////////////////

    // row runs fastest and col steps on row wrap
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fill_addr <= '0;
            wr_en     <= 1'b0;
        end else begin
            wr_en <= accept;
            if (accept) begin
                if (fill_addr.row == GRID_LAST) begin
                    fill_addr.row <= '0;
                    // col wraps to 0 after the last cell
                    fill_addr.col <= fill_addr.col + 1'b1;
                end else begin
                    fill_addr.row <= fill_addr.row + 1'b1;
                end
            end
        end
    end

    // write payload is only meaningful with wr_en
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_addr  <= fill_addr;
            wr_value <= candidate;
        end
    end

    assign wr = '{en: wr_en, addr: wr_addr, value: wr_value};

endmodule

`default_nettype wire

// File: board_store.sv
`timescale 1ns/1ps
`default_nettype none

module board_store import match_board_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire cell_write_t wr,
    input  wire cell_addr_t  rd_addr,
    output symbol_t          rd_value
);

    // board cells indexed [row][col]
    symbol_t cells [GRID_SIZE][GRID_SIZE];

    //////////////////////////////
    // write port
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // whole board back to code 0
            for (int r = 0; r < GRID_SIZE; r++) begin
                for (int c = 0; c < GRID_SIZE; c++) begin
                    cells[r][c] <= '0;
                end
            end
        end else if (wr.en) begin
            cells[wr.addr.row][wr.addr.col] <= wr.value;
        end
    end

    //////////////////////////////
    // read port
    //////////////////////////////

    // combinational read in the same cycle as the pixel
    assign rd_value = cells[rd_addr.row][rd_addr.col];

endmodule

`default_nettype wire

// File: cursor_control.sv
`timescale 1ns/1ps
`default_nettype none

module cursor_control import match_board_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic left,
    input  wire logic right,
    input  wire logic up,
    input  wire logic down,
    input  wire logic enter,
    output cursor_t   cursor
);

    localparam grid_index_t GRID_LAST = grid_index_t'(GRID_SIZE - 1);

    // key order left, right, up, down, enter
    logic [4:0]  keys;
    logic [4:0]  keys_q;
    logic        left_p;
    logic        right_p;
    logic        up_p;
    logic        down_p;
    logic        enter_p;
    grid_index_t row;
    grid_index_t col;
    logic        selected;

    assign keys = {left, right, up, down, enter};

    // previous sample of each key
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            keys_q <= '0;
        end else begin
            keys_q <= keys;
        end
    end

    // one-cycle pulse on each rising edge
    assign {left_p, right_p, up_p, down_p, enter_p} = keys & ~keys_q;

    //////////////////////////////
    // cursor position
    //////////////////////////////

    // first pending arrow wins and stops at the edges
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            row <= '0;
            col <= '0;
        end else if (!selected) begin
            if (left_p) begin
                if (col != '0) col <= col - 1'b1;
            end else if (right_p) begin
                if (col != GRID_LAST) col <= col + 1'b1;
            end else if (up_p) begin
                if (row != '0) row <= row - 1'b1;
            end else if (down_p) begin
                if (row != GRID_LAST) row <= row + 1'b1;
            end
        end
    end

    // enter flips selection, which freezes the cursor
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            selected <= 1'b0;
        end else if (enter_p) begin
            selected <= ~selected;
        end
    end

    assign cursor = '{pos: '{row: row, col: col}, selected: selected};

endmodule

`default_nettype wire

// File: match_board.f
match_board_pkg.sv
cursor_control.sv
board_filler.sv
board_store.sv
pixel_renderer.sv
match_board_top.sv
match_board_assert.sv
match_board_tb.sv

// File: match_board_assert.sv
`timescale 1ns/1ps
`default_nettype none

module match_board_assert import match_board_pkg::*; (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        video_on,
    input wire rgb_t        graph_rgb,
    input wire cell_write_t wr,
    input wire cursor_t     cursor
);

    // number of failed assertions so far
    int failures = 0;

    // only legal codes reach the store
    write_value_legal: assert property (
        @(posedge clk) disable iff (reset) wr.en |-> (wr.value < symbol_t'(NUM_SYMBOLS))
    ) else begin
        failures++;
        $error("board write carries an illegal symbol code");
    end

    // blanking wins over everything
    blank_when_video_off: assert property (
        @(posedge clk) disable iff (reset) !video_on |-> (graph_rgb == COLOR_BLANK)
    ) else begin
        failures++;
        $error("colour output not black while video is off");
    end

    // selected cursor holds still
    cursor_frozen: assert property (
        @(posedge clk) disable iff (reset) cursor.selected |=> $stable(cursor.pos)
    ) else begin
        failures++;
        $error("cursor moved while selected");
    end

endmodule

bind match_board_top match_board_assert i_match_board_assert (
    .clk       (clk),
    .reset     (reset),
    .video_on  (video_on),
    .graph_rgb (graph_rgb),
    .wr        (wr),
    .cursor    (cursor)
);

`default_nettype wire

// File: match_board_pkg.sv
`default_nettype none

package match_board_pkg;

    //////////////////////////////
    // board geometry
    //////////////////////////////

    localparam int GRID_SIZE     = 8;
    // cells are 32x32 pixels
    localparam int CELL_SHIFT    = 5;
    // symbol inset inside its cell
    localparam int SYMBOL_MARGIN = 4;
    // cursor frame thickness
    localparam int FRAME_WIDTH   = 2;
    // legal codes 0..4
    localparam int NUM_SYMBOLS   = 5;

    typedef logic [9:0]  coord_t;
    typedef logic [2:0]  grid_index_t;
    typedef logic [2:0]  symbol_t;
    // 4 bits each of r, g, b
    typedef logic [11:0] rgb_t;

    //////////////////////////////
    // colours
    //////////////////////////////

    localparam rgb_t COLOR_BLANK      = 12'h000;
    localparam rgb_t COLOR_BACKGROUND = 12'hFFF;
    localparam rgb_t COLOR_CURSOR     = 12'h0FF;
    localparam rgb_t COLOR_SELECTED   = 12'hF00;

    // yellow, green, blue, magenta, orange
    localparam rgb_t symbol_palette [NUM_SYMBOLS] = '{
        12'hFF0, 12'h0F0, 12'h00F, 12'hF0F, 12'hF80
    };

    typedef struct packed {
        grid_index_t row;
        grid_index_t col;
    } cell_addr_t;

    typedef struct packed {
        logic       en;
        cell_addr_t addr;
        symbol_t    value;
    } cell_write_t;

    typedef struct packed {
        cell_addr_t pos;
        logic       selected;
    } cursor_t;

endpackage

`default_nettype wire

// File: match_board_tb.sv
`timescale 1ns/1ps
`default_nettype none

module match_board_tb import match_board_pkg::*; ();

    localparam int ORIGIN_X  = 272;
    localparam int ORIGIN_Y  = 112;
    localparam int CELL_SIZE = 1 << CELL_SHIFT;
    localparam int IDLE_TIMEOUT = 20;
    localparam grid_index_t GRID_LAST = grid_index_t'(GRID_SIZE - 1);

    logic   clk = 1'b0;
    logic   reset;
    logic   video_on;
    coord_t pix_x;
    coord_t pix_y;
    logic   left;
    logic   right;
    logic   up;
    logic   down;
    logic   enter;
    logic   game_reset;
    rgb_t   graph_rgb;

    int seed = 6848;

    // reference state
    logic [2:0]  lfsr_model;
    symbol_t     cand_model;
    grid_index_t fill_row;
    grid_index_t fill_col;
    symbol_t     board_model [GRID_SIZE][GRID_SIZE];
    logic [4:0]  key_now;
    logic [4:0]  key_prev;
    logic [4:0]  key_pulse;
    grid_index_t cur_row;
    grid_index_t cur_col;
    logic        cur_sel;

    match_board_top i_match_board_top (
        .clk        (clk),
        .reset      (reset),
        .video_on   (video_on),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .left       (left),
        .right      (right),
        .up         (up),
        .down       (down),
        .enter      (enter),
        .game_reset (game_reset),
        .graph_rgb  (graph_rgb)
    );

    always #5 clk = ~clk;

    //////////////////////////////
    // reference model
    //////////////////////////////

    // lfsr minus one gives the code
    assign cand_model = lfsr_model - 3'd1;

    // row-first fill walk that rejects codes of 5 and up
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr_model <= 3'd1;
            fill_row   <= '0;
            fill_col   <= '0;
            for (int r = 0; r < GRID_SIZE; r++) begin
                for (int c = 0; c < GRID_SIZE; c++) begin
                    board_model[r][c] <= '0;
                end
            end
        end else begin
            lfsr_model <= {lfsr_model[1:0], lfsr_model[2] ^ lfsr_model[1]};
            if (game_reset && (cand_model < symbol_t'(NUM_SYMBOLS))) begin
                board_model[fill_row][fill_col] <= cand_model;
                if (fill_row == GRID_LAST) begin
                    fill_row <= '0;
                    fill_col <= fill_col + 3'd1;
                end else begin
                    fill_row <= fill_row + 3'd1;
                end
            end
        end
    end

    // key order left, right, up, down, enter
    assign key_now   = {left, right, up, down, enter};
    assign key_pulse = key_now & ~key_prev;

    // cursor moves on the first pending arrow unless selected
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            key_prev <= '0;
            cur_row  <= '0;
            cur_col  <= '0;
            cur_sel  <= 1'b0;
        end else begin
            key_prev <= key_now;
            if (!cur_sel) begin
                if (key_pulse[4]) begin
                    if (cur_col != '0) cur_col <= cur_col - 3'd1;
                end else if (key_pulse[3]) begin
                    if (cur_col != GRID_LAST) cur_col <= cur_col + 3'd1;
                end else if (key_pulse[2]) begin
                    if (cur_row != '0) cur_row <= cur_row - 3'd1;
                end else if (key_pulse[1]) begin
                    if (cur_row != GRID_LAST) cur_row <= cur_row + 3'd1;
                end
            end
            if (key_pulse[0]) cur_sel <= ~cur_sel;
        end
    end

    // expected colour of one pixel from the model state
    function automatic rgb_t expected_color(int x, int y, logic vid);
        int dx;
        int dy;
        int ox;
        int oy;
        grid_index_t r;
        grid_index_t c;
        bit in_frame;
        dx = x - ORIGIN_X;
        dy = y - ORIGIN_Y;
        if (!vid) return COLOR_BLANK;
        if (dx < 0 || dy < 0 || dx >= GRID_SIZE * CELL_SIZE || dy >= GRID_SIZE * CELL_SIZE)
            return COLOR_BACKGROUND;
        r  = grid_index_t'(dy / CELL_SIZE);
        c  = grid_index_t'(dx / CELL_SIZE);
        ox = dx % CELL_SIZE;
        oy = dy % CELL_SIZE;
        in_frame = (r == cur_row) && (c == cur_col)
                && (ox < FRAME_WIDTH || ox >= CELL_SIZE - FRAME_WIDTH
                 || oy < FRAME_WIDTH || oy >= CELL_SIZE - FRAME_WIDTH);
        if (in_frame) return cur_sel ? COLOR_SELECTED : COLOR_CURSOR;
        if (ox >= SYMBOL_MARGIN && ox < CELL_SIZE - SYMBOL_MARGIN
         && oy >= SYMBOL_MARGIN && oy < CELL_SIZE - SYMBOL_MARGIN)
            return symbol_palette[board_model[r][c]];
        return COLOR_BACKGROUND;
    endfunction

    //////////////////////////////
    // checking helpers
    //////////////////////////////

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // stop on the first failed design assertion
    always @(negedge clk) begin
        if (i_match_board_top.i_match_board_assert.failures != 0)
            report_failure("A concurrent assertion on the design failed");
    end

    task automatic check_value(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp)
            report_failure($sformatf("Mismatch %s got %h expected %h", name, got, exp));
    endtask

    // new pixel on the falling edge and settle before sampling
    task automatic drive_pixel(input int x, input int y, input logic vid);
        @(negedge clk);
        pix_x    = coord_t'(x);
        pix_y    = coord_t'(y);
        video_on = vid;
        #1;
    endtask

    task automatic probe(input int x, input int y, input logic vid);
        drive_pixel(x, y, vid);
        check_value($sformatf("graph_rgb at %0d,%0d video_on %0b", x, y, vid),
                    graph_rgb, expected_color(x, y, vid));
    endtask

    // frame band corners and edges plus the centre
    task automatic probe_cell(input int r, input int c);
        int ox [6] = '{0, 1, 31, 16, 30, 16};
        int oy [6] = '{0, 16, 31, 30, 1, 16};
        for (int i = 0; i < 6; i++) begin
            probe(ORIGIN_X + c * CELL_SIZE + ox[i], ORIGIN_Y + r * CELL_SIZE + oy[i], 1'b1);
        end
    endtask

    // one cycle high then low
    // keys 0 to 4 are left right up down enter
    task automatic press_key(input int k);
        @(negedge clk);
        case (k)
            0: left  = 1'b1;
            1: right = 1'b1;
            2: up    = 1'b1;
            3: down  = 1'b1;
            default: enter = 1'b1;
        endcase
        @(negedge clk);
        {left, right, up, down, enter} = '0;
    endtask

    // last fill write lands one edge after it is issued
    task automatic wait_fill_idle();
        int cycles;
        cycles = 0;
        while (i_match_board_top.wr.en !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > IDLE_TIMEOUT)
                report_failure("Timeout waiting for the board fill writes to stop");
        end
    endtask

    task automatic fill_board();
        int hold;
        hold = 50 + ($unsigned($random(seed)) % 151);
        @(negedge clk);
        game_reset = 1'b1;
        repeat (hold) @(negedge clk);
        game_reset = 1'b0;
        wait_fill_idle();
        for (int r = 0; r < GRID_SIZE; r++) begin
            for (int c = 0; c < GRID_SIZE; c++) begin
                probe(ORIGIN_X + c * CELL_SIZE + 16, ORIGIN_Y + r * CELL_SIZE + 16, 1'b1);
            end
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        int old_r;
        int old_c;
        reset      = 1'b1;
        video_on   = 1'b0;
        pix_x      = '0;
        pix_y      = '0;
        {left, right, up, down, enter} = '0;
        game_reset = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // cleared board with the cursor at 0,0
        for (int r = 0; r < GRID_SIZE; r++) begin
            for (int c = 0; c < GRID_SIZE; c++) begin
                probe_cell(r, c);
                drive_pixel(ORIGIN_X + c * CELL_SIZE + 16, ORIGIN_Y + r * CELL_SIZE + 16, 1'b1);
                check_value("graph_rgb cell centre", graph_rgb, symbol_palette[0]);
            end
        end
        drive_pixel(ORIGIN_X, ORIGIN_Y, 1'b1);
        check_value("graph_rgb cursor corner", graph_rgb, COLOR_CURSOR);
        drive_pixel(10, 10, 1'b1);
        check_value("graph_rgb off board", graph_rgb, COLOR_BACKGROUND);
        drive_pixel(ORIGIN_X + 48, ORIGIN_Y + 48, 1'b0);
        check_value("graph_rgb video off", graph_rgb, COLOR_BLANK);
        probe(639, 479, 1'b1);
        probe(ORIGIN_X, ORIGIN_Y, 1'b0);

        // random arrows including blocked moves at the edges
        for (int i = 0; i < 40; i++) begin
            old_r = cur_row;
            old_c = cur_col;
            press_key($unsigned($random(seed)) % 4);
            probe_cell(old_r, old_c);
            probe_cell(cur_row, cur_col);
        end

        // selection freezes the cursor
        press_key(4);
        probe_cell(cur_row, cur_col);
        old_r = cur_row;
        old_c = cur_col;
        for (int i = 0; i < 8; i++) begin
            press_key($unsigned($random(seed)) % 4);
            drive_pixel(ORIGIN_X + old_c * CELL_SIZE, ORIGIN_Y + old_r * CELL_SIZE, 1'b1);
            check_value("graph_rgb selected frame", graph_rgb, COLOR_SELECTED);
        end
        press_key(4);
        probe_cell(cur_row, cur_col);
        drive_pixel(ORIGIN_X + old_c * CELL_SIZE, ORIGIN_Y + old_r * CELL_SIZE, 1'b1);
        check_value("graph_rgb released frame", graph_rgb, COLOR_CURSOR);

        // two fills where long runs wrap past 64 writes
        fill_board();
        fill_board();

        // walk to col 0, then a held right moves once
        repeat (GRID_SIZE) press_key(0);
        @(negedge clk);
        right = 1'b1;
        repeat (10) @(negedge clk);
        right = 1'b0;
        drive_pixel(ORIGIN_X + CELL_SIZE, ORIGIN_Y + cur_row * CELL_SIZE, 1'b1);
        check_value("graph_rgb held key col 1", graph_rgb, COLOR_CURSOR);
        drive_pixel(ORIGIN_X, ORIGIN_Y + cur_row * CELL_SIZE, 1'b1);
        check_value("graph_rgb held key col 0", graph_rgb, COLOR_BACKGROUND);
        drive_pixel(ORIGIN_X + 2 * CELL_SIZE, ORIGIN_Y + cur_row * CELL_SIZE, 1'b1);
        check_value("graph_rgb held key col 2", graph_rgb, COLOR_BACKGROUND);
        probe_cell(cur_row, 1);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: match_board_top.sv
`timescale 1ns/1ps
`default_nettype none

module match_board_top import match_board_pkg::*; #(
    parameter coord_t BOARD_ORIGIN_X = 10'd272,
    parameter coord_t BOARD_ORIGIN_Y = 10'd112
) (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   video_on,
    input  wire coord_t pix_x,
    input  wire coord_t pix_y,
    input  wire logic   left,
    input  wire logic   right,
    input  wire logic   up,
    input  wire logic   down,
    input  wire logic   enter,
    input  wire logic   game_reset,
    output rgb_t        graph_rgb
);

    cursor_t     cursor;
    cell_write_t wr;
    cell_addr_t  rd_addr;
    symbol_t     rd_value;

    // keys to cursor and selection
    cursor_control i_cursor_control (
        .clk    (clk),
        .reset  (reset),
        .left   (left),
        .right  (right),
        .up     (up),
        .down   (down),
        .enter  (enter),
        .cursor (cursor)
    );

    // random board fill while game_reset is held
    board_filler i_board_filler (
        .clk        (clk),
        .reset      (reset),
        .game_reset (game_reset),
        .wr         (wr)
    );

    board_store i_board_store (
        .clk      (clk),
        .reset    (reset),
        .wr       (wr),
        .rd_addr  (rd_addr),
        .rd_value (rd_value)
    );

    // per-pixel colour
    pixel_renderer #(
        .BOARD_ORIGIN_X (BOARD_ORIGIN_X),
        .BOARD_ORIGIN_Y (BOARD_ORIGIN_Y)
    ) i_pixel_renderer (
        .video_on  (video_on),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .cursor    (cursor),
        .rd_value  (rd_value),
        .rd_addr   (rd_addr),
        .graph_rgb (graph_rgb)
    );

endmodule

`default_nettype wire

// File: pixel_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_renderer import match_board_pkg::*; #(
    parameter coord_t BOARD_ORIGIN_X = 10'd272,
    parameter coord_t BOARD_ORIGIN_Y = 10'd112
) (
    input  wire logic    video_on,
    input  wire coord_t  pix_x,
    input  wire coord_t  pix_y,
    input  wire cursor_t cursor,
    input  wire symbol_t rd_value,
    output cell_addr_t   rd_addr,
    output rgb_t         graph_rgb
);

    // 8 cells of 32 pixels
    localparam int BOARD_PIXELS = GRID_SIZE << CELL_SHIFT;
    localparam int CELL_SIZE    = 1 << CELL_SHIFT;

    localparam coord_t BOARD_SPAN = coord_t'(BOARD_PIXELS);

    typedef logic [CELL_SHIFT-1:0] offset_t;

    // frame covers offsets 0..1 and 30..31
    localparam offset_t FRAME_LO = offset_t'(FRAME_WIDTH);
    localparam offset_t FRAME_HI = offset_t'(CELL_SIZE - FRAME_WIDTH);
    // symbol covers offsets 4..27
    localparam offset_t SYM_LO   = offset_t'(SYMBOL_MARGIN);
    localparam offset_t SYM_HI   = offset_t'(CELL_SIZE - SYMBOL_MARGIN);

    coord_t  dx;
    coord_t  dy;
    logic    on_board;
    offset_t off_x;
    offset_t off_y;
    logic    in_cursor_cell;
    logic    in_frame;
    logic    in_symbol;

    //////////////////////////////
    // pixel to cell
    //////////////////////////////

    // offset from the board's top left corner
    assign dx = pix_x - BOARD_ORIGIN_X;
    assign dy = pix_y - BOARD_ORIGIN_Y;

    // lower bound checked on the raw coordinate, upper on the offset
    assign on_board = (pix_x >= BOARD_ORIGIN_X) && (dx < BOARD_SPAN)
                   && (pix_y >= BOARD_ORIGIN_Y) && (dy < BOARD_SPAN);

    // upper offset bits pick the cell
    assign rd_addr.row = dy[CELL_SHIFT +: $bits(grid_index_t)];
    assign rd_addr.col = dx[CELL_SHIFT +: $bits(grid_index_t)];

    // low bits give position within the cell
    assign off_x = dx[CELL_SHIFT-1:0];
    assign off_y = dy[CELL_SHIFT-1:0];

    assign in_cursor_cell = on_board && (rd_addr == cursor.pos);

    // edge band of the cursor cell
    assign in_frame = in_cursor_cell
                   && ((off_x < FRAME_LO) || (off_x >= FRAME_HI)
                    || (off_y < FRAME_LO) || (off_y >= FRAME_HI));

    assign in_symbol = on_board
                    && (off_x >= SYM_LO) && (off_x < SYM_HI)
                    && (off_y >= SYM_LO) && (off_y < SYM_HI);

    //////////////////////////////
    // colour mux
    //////////////////////////////

    // blank, then frame, then symbol, then background
    always_comb begin
        if (!video_on) begin
            graph_rgb = COLOR_BLANK;
        end else if (in_frame) begin
            graph_rgb = cursor.selected ? COLOR_SELECTED : COLOR_CURSOR;
        end else if (in_symbol && (rd_value < symbol_t'(NUM_SYMBOLS))) begin
            graph_rgb = symbol_palette[rd_value];
        end else begin
            // also covers an illegal code in the store
            graph_rgb = COLOR_BACKGROUND;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the match board simulation with Verilator

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal -f match_board.f \
        --top-module match_board_tb -o sim_match_board; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_match_board 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" <<< "$output"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
